/* logic/bridge_pkg.sv */
// SpiNNaker AER bridge shared definitions
// packet layout, control command codes and reset values
// used by every block in the event path

`default_nettype none

package bridge_pkg;

  // --------------------------------------
  // packet layout
  // --------------------------------------
  // multicast packet width
  localparam int PKT_BITS    = 40;
  // routing key, packet bits 39..8
  localparam int KEY_BITS    = 32;
  // header, bit 0 is parity, rest zero
  localparam int HDR_BITS    = 8;
  // AER address width
  localparam int AER_BITS    = 16;
  // virtual key forms upper key half
  localparam int VKEY_BITS   = 16;

  // request and ack synchroniser depth
  localparam int SYNC_STAGES = 2;

  // --------------------------------------
  // control packets
  // --------------------------------------
  // key bits 31..24 of a control packet
  localparam logic [7:0] CTRL_PREFIX = 8'hFE;
  // command codes in key bits 23..16
  localparam logic [7:0] CMD_VKEY    = 8'd1;
  localparam logic [7:0] CMD_GO      = 8'd2;
  localparam logic [7:0] CMD_STOP    = 8'd3;

  // virtual key out of reset
  localparam logic [VKEY_BITS-1:0] VKEY_RESET = 16'h0200;

  // stalled cycles before a held packet is dropped
  localparam int DUMP_TIMEOUT = 64;

endpackage

`default_nettype wire

/* logic/aer_in_mapper.sv */
// AER input to SpiNNaker packet mapper
// runs the input 4-phase handshake on a synchronised request
// and turns each event into a parity-protected multicast packet

`timescale 1ns/1ps
`default_nettype none

module aer_in_mapper
  import bridge_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic [VKEY_BITS-1:0] i_vkey,
  input  logic [AER_BITS-1:0]  i_iaer_data,
  input  logic                 i_iaer_req,
  output logic                 o_iaer_ack,
  output logic [PKT_BITS-1:0]  o_mpkt_data,
  output logic                 o_mpkt_vld,
  input  logic                 i_mpkt_rdy
);

  // request synchroniser, idles high
  logic [SYNC_STAGES-1:0] req_sync;
  logic                   s_req;

  logic [KEY_BITS-1:0]    key_next;
  logic [HDR_BITS-1:0]    hdr_next;
  logic                   capture;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      req_sync <= '1;
    end else begin
      req_sync <= {req_sync[SYNC_STAGES-2:0], i_iaer_req};
    end
  end

  assign s_req = req_sync[SYNC_STAGES-1];

  // --------------------------------------
  // packet build
  // --------------------------------------
  // key is virtual key then event address
  assign key_next = {i_vkey, i_iaer_data};
  // parity bit set on an even key weight, packet weight stays odd
  assign hdr_next = {{(HDR_BITS-1){1'b0}}, ~^key_next};

  // new event only with ack idle and the slot free
  assign capture = o_iaer_ack && !s_req && !o_mpkt_vld;

  // --------------------------------------
  // handshake and output slot
  // --------------------------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_iaer_ack <= 1'b1;
      o_mpkt_vld <= 1'b0;
    end else begin
      if (capture) begin
        // ack low, event taken
        o_iaer_ack <= 1'b0;
      end else if (!o_iaer_ack && s_req) begin
        // request released, close the 4-phase cycle
        o_iaer_ack <= 1'b1;
      end
      if (capture) begin
        o_mpkt_vld <= 1'b1;
      end else if (i_mpkt_rdy) begin
        o_mpkt_vld <= 1'b0;
      end
    end
  end

  // payload register
  always_ff @(posedge i_clk) begin
    if (capture) begin
      o_mpkt_data <= {key_next, hdr_next};
    end
  end

endmodule

`default_nettype wire

/* logic/pkt_dump.sv */
// packet dump between the input mapper and the SpiNNaker side
// drops every event while the flow is stopped and drops a
// packet that has been stalled for too long

`timescale 1ns/1ps
`default_nettype none

module pkt_dump
  import bridge_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_go,
  input  logic [PKT_BITS-1:0] i_mpkt_data,
  input  logic                i_mpkt_vld,
  output logic                o_mpkt_rdy,
  output logic [PKT_BITS-1:0] o_ipkt_data,
  output logic                o_ipkt_vld,
  input  logic                i_ipkt_rdy
);

  localparam int CNT_BITS = $clog2(DUMP_TIMEOUT + 1);

  // consecutive stalled cycles
  logic [CNT_BITS-1:0] stall_cnt;
  logic                timeout;
  logic                stalled;

  // --------------------------------------
  // stall timer
  // --------------------------------------
  assign timeout = (stall_cnt == CNT_BITS'(DUMP_TIMEOUT));
  // valid held back by the peer
  assign stalled = i_go && i_mpkt_vld && !i_ipkt_rdy;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      stall_cnt <= '0;
    end else if (stalled && !timeout) begin
      stall_cnt <= stall_cnt + 1'b1;
    end else begin
      // restart on progress, on stop, or after a drop
      stall_cnt <= '0;
    end
  end

  // --------------------------------------
  // pass or discard
  // --------------------------------------
  // data goes straight through, no added cycle
  assign o_ipkt_data = i_mpkt_data;

  always_comb begin
    if (!i_go) begin
      // flow stopped, swallow everything
      o_ipkt_vld = 1'b0;
      o_mpkt_rdy = 1'b1;
    end else if (timeout) begin
      // one cycle dump of the held packet
      o_ipkt_vld = 1'b0;
      o_mpkt_rdy = 1'b1;
    end else begin
      o_ipkt_vld = i_mpkt_vld;
      o_mpkt_rdy = i_ipkt_rdy;
    end
  end

endmodule

`default_nettype wire

/* logic/pkt_router.sv */
// packet router for traffic from the SpiNNaker side
// one-entry buffer, control packets go to the controller
// and all others to the output AER mapper

`timescale 1ns/1ps
`default_nettype none

module pkt_router
  import bridge_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic [PKT_BITS-1:0] i_spkt_data,
  input  logic                i_spkt_vld,
  output logic                o_spkt_rdy,
  output logic [PKT_BITS-1:0] o_opkt_data,
  output logic                o_opkt_vld,
  input  logic                i_opkt_rdy,
  output logic [PKT_BITS-1:0] o_cpkt_data,
  output logic                o_cpkt_vld,
  input  logic                i_cpkt_rdy
);

  logic [PKT_BITS-1:0] buf_data;
  logic                buf_vld;
  logic [KEY_BITS-1:0] buf_key;
  logic                is_ctrl;
  logic                drain;

  // key prefix picks the destination
  assign buf_key = buf_data[PKT_BITS-1:HDR_BITS];
  assign is_ctrl = (buf_key[KEY_BITS-1 -: 8] == CTRL_PREFIX);

  assign o_spkt_rdy  = !buf_vld;
  assign o_cpkt_data = buf_data;
  assign o_opkt_data = buf_data;
  assign o_cpkt_vld  = buf_vld && is_ctrl;
  assign o_opkt_vld  = buf_vld && !is_ctrl;

  // handshake on whichever link holds the packet
  assign drain = (o_cpkt_vld && i_cpkt_rdy) || (o_opkt_vld && i_opkt_rdy);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      buf_vld <= 1'b0;
    end else if (i_spkt_vld && o_spkt_rdy) begin
      buf_vld <= 1'b1;
    end else if (drain) begin
      buf_vld <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_spkt_vld && o_spkt_rdy) begin
      buf_data <= i_spkt_data;
    end
  end

endmodule

`default_nettype wire

/* logic/bridge_control.sv */
// bridge controller
// decodes command packets into the virtual key and the
// go flag that opens the event flow

`timescale 1ns/1ps
`default_nettype none

module bridge_control
  import bridge_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic [PKT_BITS-1:0]  i_cpkt_data,
  input  logic                 i_cpkt_vld,
  output logic                 o_cpkt_rdy,
  output logic [VKEY_BITS-1:0] o_vkey,
  output logic                 o_go
);

  logic [KEY_BITS-1:0] key;
  logic [7:0]          prefix;
  logic [7:0]          cmd;
  logic                cmd_ok;

  // --------------------------------------
  // command fields
  // --------------------------------------
  assign key    = i_cpkt_data[PKT_BITS-1:HDR_BITS];
  assign prefix = key[KEY_BITS-1 -: 8];
  assign cmd    = key[KEY_BITS-9 -: 8];

  // router only sends control packets, prefix check is a guard
  assign cmd_ok = i_cpkt_vld && (prefix == CTRL_PREFIX);

  // commands always consumed in one cycle
  assign o_cpkt_rdy = 1'b1;

  // --------------------------------------
  // control registers
  // --------------------------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_vkey <= VKEY_RESET;
      o_go   <= 1'b0;
    end else if (cmd_ok) begin
      case (cmd)
        // new key rides in the low key half
        CMD_VKEY: o_vkey <= key[VKEY_BITS-1:0];
        CMD_GO:   o_go   <= 1'b1;
        CMD_STOP: o_go   <= 1'b0;
        // unknown codes are dropped
        default: begin
          o_go <= o_go;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/aer_out_mapper.sv */
// SpiNNaker packet to AER output mapper
// FSM that replays each output event as a 4-phase
// handshake with active-low request and ack

`timescale 1ns/1ps
`default_nettype none

module aer_out_mapper
  import bridge_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic [PKT_BITS-1:0] i_opkt_data,
  input  logic                i_opkt_vld,
  output logic                o_opkt_rdy,
  output logic [AER_BITS-1:0] o_oaer_data,
  output logic                o_oaer_req,
  input  logic                i_oaer_ack
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_ACK_HI,
    ST_RETURN
  } state_t;

  state_t state;

  // ack synchroniser, idles high
  logic [SYNC_STAGES-1:0] ack_sync;
  logic                   s_ack;
  logic [KEY_BITS-1:0]    key;
  logic                   accept;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ack_sync <= '1;
    end else begin
      ack_sync <= {ack_sync[SYNC_STAGES-2:0], i_oaer_ack};
    end
  end

  assign s_ack = ack_sync[SYNC_STAGES-1];

  // event address is the low key half
  assign key        = i_opkt_data[PKT_BITS-1:HDR_BITS];
  assign o_opkt_rdy = (state == ST_IDLE);
  assign accept     = i_opkt_vld && o_opkt_rdy;

  // --------------------------------------
  // handshake sequencer
  // --------------------------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state      <= ST_IDLE;
      o_oaer_req <= 1'b1;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            o_oaer_req <= 1'b0;
            state      <= ST_REQ;
          end
        end
        // device took the address, drop the request
        ST_REQ: begin
          if (!s_ack) begin
            o_oaer_req <= 1'b1;
            state      <= ST_ACK_HI;
          end
        end
        // wait for the device to release ack
        ST_ACK_HI: begin
          if (s_ack) begin
            state <= ST_RETURN;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // address held while the request is low
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_oaer_data <= key[AER_BITS-1:0];
    end
  end

endmodule

`default_nettype wire

/* logic/spinn_aer_bridge.sv */
// SpiNNaker link to AER device bridge, packet level
// input events are mapped to packets and gated by the dump,
// incoming packets are routed to the controller or the output

`timescale 1ns/1ps
`default_nettype none

module spinn_aer_bridge
  import bridge_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_arst_n,

  // input AER device
  input  logic [AER_BITS-1:0] i_iaer_data,
  input  logic                i_iaer_req,
  output logic                o_iaer_ack,

  // output AER device
  output logic [AER_BITS-1:0] o_oaer_data,
  output logic                o_oaer_req,
  input  logic                i_oaer_ack,

  // packets from SpiNNaker
  input  logic [PKT_BITS-1:0] i_spkt_data,
  input  logic                i_spkt_vld,
  output logic                o_spkt_rdy,

  // packets to SpiNNaker
  output logic [PKT_BITS-1:0] o_ipkt_data,
  output logic                o_ipkt_vld,
  input  logic                i_ipkt_rdy
);

  // router to output mapper
  logic [PKT_BITS-1:0]  opkt_data;
  logic                 opkt_vld;
  logic                 opkt_rdy;
  // router to controller
  logic [PKT_BITS-1:0]  cpkt_data;
  logic                 cpkt_vld;
  logic                 cpkt_rdy;
  // input mapper to dump
  logic [PKT_BITS-1:0]  mpkt_data;
  logic                 mpkt_vld;
  logic                 mpkt_rdy;

  // control state
  logic [VKEY_BITS-1:0] vkey;
  logic                 go;

  // --------------------------------------
  // SpiNNaker to AER path
  // --------------------------------------
  pkt_router pkt_router_i (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_spkt_data (i_spkt_data),
    .i_spkt_vld  (i_spkt_vld),
    .o_spkt_rdy  (o_spkt_rdy),
    .o_opkt_data (opkt_data),
    .o_opkt_vld  (opkt_vld),
    .i_opkt_rdy  (opkt_rdy),
    .o_cpkt_data (cpkt_data),
    .o_cpkt_vld  (cpkt_vld),
    .i_cpkt_rdy  (cpkt_rdy)
  );

  aer_out_mapper aer_out_mapper_i (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_opkt_data (opkt_data),
    .i_opkt_vld  (opkt_vld),
    .o_opkt_rdy  (opkt_rdy),
    .o_oaer_data (o_oaer_data),
    .o_oaer_req  (o_oaer_req),
    .i_oaer_ack  (i_oaer_ack)
  );

  bridge_control bridge_control_i (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_cpkt_data (cpkt_data),
    .i_cpkt_vld  (cpkt_vld),
    .o_cpkt_rdy  (cpkt_rdy),
    .o_vkey      (vkey),
    .o_go        (go)
  );

  // --------------------------------------
  // AER to SpiNNaker path
  // --------------------------------------
  aer_in_mapper aer_in_mapper_i (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_vkey      (vkey),
    .i_iaer_data (i_iaer_data),
    .i_iaer_req  (i_iaer_req),
    .o_iaer_ack  (o_iaer_ack),
    .o_mpkt_data (mpkt_data),
    .o_mpkt_vld  (mpkt_vld),
    .i_mpkt_rdy  (mpkt_rdy)
  );

  pkt_dump pkt_dump_i (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_go        (go),
    .i_mpkt_data (mpkt_data),
    .i_mpkt_vld  (mpkt_vld),
    .o_mpkt_rdy  (mpkt_rdy),
    .o_ipkt_data (o_ipkt_data),
    .o_ipkt_vld  (o_ipkt_vld),
    .i_ipkt_rdy  (i_ipkt_rdy)
  );

endmodule

`default_nettype wire

/* tests/bridge_chk.sv */
// protocol checker for the bridge top level
// bound into the DUT, watches both AER ports and the packet output

`timescale 1ns/1ps
`default_nettype none

module bridge_chk
  import bridge_pkg::*;
(
  input logic                i_clk,
  input logic                i_arst_n,
  input logic [AER_BITS-1:0] o_oaer_data,
  input logic                o_oaer_req,
  input logic [PKT_BITS-1:0] o_ipkt_data,
  input logic                o_ipkt_vld,
  input logic                i_iaer_req,
  input logic                o_iaer_ack
);

  // output address held for the whole low request
  a_oaer_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !o_oaer_req |=> (o_oaer_req || $stable(o_oaer_data)))
    else $error("output AER address changed while request low");

  // every offered packet has odd weight
  a_ipkt_parity: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_ipkt_vld |-> ^o_ipkt_data)
    else $error("packet offered with even parity");

  // 4-phase rule on the input side
  a_iaer_ack_rise: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $rose(o_iaer_ack) |-> i_iaer_req)
    else $error("input ack released before the request");

endmodule

bind spinn_aer_bridge bridge_chk chk_i (
  .i_clk       (i_clk),
  .i_arst_n    (i_arst_n),
  .o_oaer_data (o_oaer_data),
  .o_oaer_req  (o_oaer_req),
  .o_ipkt_data (o_ipkt_data),
  .o_ipkt_vld  (o_ipkt_vld),
  .i_iaer_req  (i_iaer_req),
  .o_iaer_ack  (o_iaer_ack)
);

`default_nettype wire

/* tests/tb_spinn_aer_bridge.sv */
// testbench for the SpiNNaker AER bridge
// table of events and packets checked against a reference model,
// with device models on the input and output AER ports

`timescale 1ns/1ps
`default_nettype none

module tb_spinn_aer_bridge
  import bridge_pkg::*;
();

  typedef enum logic [1:0] {K_AER, K_PKT, K_STALL} kind_t;

  typedef struct packed {
    kind_t               kind;
    logic                has_exp;
    logic [PKT_BITS-1:0] val;
    logic [PKT_BITS-1:0] exp;
  } entry_t;

  logic                i_clk = 1'b0;
  logic                i_arst_n;
  logic [AER_BITS-1:0] i_iaer_data;
  logic                i_iaer_req;
  logic                o_iaer_ack;
  logic [AER_BITS-1:0] o_oaer_data;
  logic                o_oaer_req;
  logic                i_oaer_ack;
  logic [PKT_BITS-1:0] i_spkt_data;
  logic                i_spkt_vld;
  logic                o_spkt_rdy;
  logic [PKT_BITS-1:0] o_ipkt_data;
  logic                o_ipkt_vld;
  logic                i_ipkt_rdy;

  entry_t              tests[$];
  // packets and output events seen so far, read by index
  logic [PKT_BITS-1:0] got_pkts[$];
  logic [AER_BITS-1:0] got_evs[$];
  int                  pkt_rd = 0;
  int                  ev_rd = 0;
  int                  n_entries = 0;
  int                  err_cnt = 0;
  int                  pass_cnt = 0;
  int                  fail_cnt = 0;
  // reference model state
  logic [VKEY_BITS-1:0] model_vkey;
  logic                 model_go;

  spinn_aer_bridge dut_i (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_iaer_data (i_iaer_data),
    .i_iaer_req  (i_iaer_req),
    .o_iaer_ack  (o_iaer_ack),
    .o_oaer_data (o_oaer_data),
    .o_oaer_req  (o_oaer_req),
    .i_oaer_ack  (i_oaer_ack),
    .i_spkt_data (i_spkt_data),
    .i_spkt_vld  (i_spkt_vld),
    .o_spkt_rdy  (o_spkt_rdy),
    .o_ipkt_data (o_ipkt_data),
    .o_ipkt_vld  (o_ipkt_vld),
    .i_ipkt_rdy  (i_ipkt_rdy)
  );

  // 20 ns period
  always #10 i_clk = ~i_clk;

  // packet monitor, handshake completes on the next rising edge
  always @(negedge i_clk) begin
    if (i_arst_n && o_ipkt_vld && i_ipkt_rdy) begin
      got_pkts.push_back(o_ipkt_data);
    end
  end

  // output device, acks each request after one cycle
  initial begin
    i_oaer_ack = 1'b1;
    forever begin
      @(negedge i_clk);
      if (i_arst_n && !o_oaer_req) begin
        got_evs.push_back(o_oaer_data);
        @(posedge i_clk);
        #1;
        i_oaer_ack = 1'b0;
        while (!o_oaer_req) begin
          @(negedge i_clk);
        end
        @(posedge i_clk);
        #1;
        i_oaer_ack = 1'b1;
      end
    end
  end

  // --------------------------------------
  // reference model
  // --------------------------------------
  // parity bit set on an even count of ones in the key
  function automatic logic [PKT_BITS-1:0] with_header(input logic [KEY_BITS-1:0] key);
    int ones;
    ones = 0;
    for (int i = 0; i < KEY_BITS; i++) begin
      if (key[i]) begin
        ones++;
      end
    end
    return {key, {(HDR_BITS-1){1'b0}}, ((ones % 2) == 0)};
  endfunction

  function automatic logic [AER_BITS-1:0] rnd_addr();
    return AER_BITS'($urandom);
  endfunction

  // any key outside the control prefix
  function automatic logic [KEY_BITS-1:0] rnd_out_key();
    logic [KEY_BITS-1:0] key;
    key = $urandom;
    if (key[KEY_BITS-1 -: 8] == CTRL_PREFIX) begin
      key[KEY_BITS-1 -: 8] = 8'h00;
    end
    return key;
  endfunction

  task automatic add_aer(input logic [AER_BITS-1:0] addr);
    entry_t e;
    e.kind    = K_AER;
    e.val     = PKT_BITS'(addr);
    e.has_exp = model_go;
    e.exp     = with_header({model_vkey, addr});
    tests.push_back(e);
  endtask

  task automatic add_stall(input logic [AER_BITS-1:0] addr);
    entry_t e;
    e.kind    = K_STALL;
    e.val     = PKT_BITS'(addr);
    e.has_exp = 1'b0;
    e.exp     = '0;
    tests.push_back(e);
  endtask

  task automatic add_ctrl(input logic [7:0] cmd, input logic [15:0] arg);
    entry_t e;
    e.kind    = K_PKT;
    e.val     = with_header({CTRL_PREFIX, cmd, arg});
    e.has_exp = 1'b0;
    e.exp     = '0;
    tests.push_back(e);
    // unknown codes leave the model alone
    if (cmd == CMD_VKEY) begin
      model_vkey = arg;
    end else if (cmd == CMD_GO) begin
      model_go = 1'b1;
    end else if (cmd == CMD_STOP) begin
      model_go = 1'b0;
    end
  endtask

  task automatic add_out(input logic [KEY_BITS-1:0] key);
    entry_t e;
    e.kind    = K_PKT;
    e.val     = with_header(key);
    e.has_exp = 1'b1;
    e.exp     = PKT_BITS'(key[AER_BITS-1:0]);
    tests.push_back(e);
  endtask

  task automatic build_table();
    model_vkey = VKEY_RESET;
    model_go   = 1'b0;
    // go clear, events are swallowed
    add_aer(rnd_addr());
    add_aer(rnd_addr());
    add_ctrl(CMD_VKEY, 16'h5a3c);
    add_ctrl(CMD_GO, 16'h0000);
    repeat (4) add_aer(rnd_addr());
    repeat (4) add_out(rnd_out_key());
    add_stall(rnd_addr());
    add_aer(rnd_addr());
    add_ctrl(CMD_STOP, 16'h0000);
    add_aer(rnd_addr());
    // unknown code carries a key that must not load
    add_ctrl(8'h07, 16'h1234);
    add_ctrl(CMD_GO, 16'h0000);
    add_aer(rnd_addr());
  endtask

  // --------------------------------------
  // drivers and checks
  // --------------------------------------
  task automatic check_value(input string name, input logic [PKT_BITS-1:0] exp,
                             input logic [PKT_BITS-1:0] act);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  // input device, one full 4-phase cycle
  task automatic drive_aer_event(input logic [AER_BITS-1:0] addr);
    int n;
    @(posedge i_clk);
    #1;
    i_iaer_data = addr;
    i_iaer_req  = 1'b0;
    n = 0;
    while (o_iaer_ack && n < 200) begin
      @(negedge i_clk);
      n++;
    end
    if (o_iaer_ack) begin
      $display("ERROR at %0t ns: input ack never went low", $time);
      err_cnt++;
    end
    @(posedge i_clk);
    #1;
    i_iaer_req = 1'b1;
    n = 0;
    while (!o_iaer_ack && n < 200) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_iaer_ack) begin
      $display("ERROR at %0t ns: input ack never returned high", $time);
      err_cnt++;
    end
  endtask

  task automatic send_pkt(input logic [PKT_BITS-1:0] pkt);
    int n;
    @(posedge i_clk);
    #1;
    i_spkt_data = pkt;
    i_spkt_vld  = 1'b1;
    n = 0;
    @(negedge i_clk);
    while (!o_spkt_rdy && n < 200) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_spkt_rdy) begin
      $display("ERROR at %0t ns: packet input never became ready", $time);
      err_cnt++;
    end
    @(posedge i_clk);
    #1;
    i_spkt_vld = 1'b0;
  endtask

  task automatic expect_pkt(input logic has_exp, input logic [PKT_BITS-1:0] exp);
    int n;
    n = 0;
    if (has_exp) begin
      while (got_pkts.size() <= pkt_rd && n < 200) begin
        @(negedge i_clk);
        n++;
      end
      if (got_pkts.size() <= pkt_rd) begin
        $display("ERROR at %0t ns: no packet came out for the event", $time);
        err_cnt++;
      end else begin
        check_value("o_ipkt_data", exp, got_pkts[pkt_rd]);
        pkt_rd++;
      end
    end else if (got_pkts.size() > pkt_rd) begin
      $display("ERROR at %0t ns: a packet came out that should be dropped", $time);
      err_cnt++;
      pkt_rd = got_pkts.size();
    end
  endtask

  task automatic expect_ev(input logic has_exp, input logic [PKT_BITS-1:0] exp);
    int n;
    n = 0;
    if (has_exp) begin
      while ((got_evs.size() <= ev_rd || !o_oaer_req) && n < 400) begin
        @(negedge i_clk);
        n++;
      end
      if (got_evs.size() <= ev_rd || !o_oaer_req) begin
        $display("ERROR at %0t ns: output AER handshake did not complete", $time);
        err_cnt++;
      end else begin
        check_value("o_oaer_data", exp, PKT_BITS'(got_evs[ev_rd]));
        ev_rd++;
      end
    end else begin
      // control packet, wait for the router to drain it
      while (!o_spkt_rdy && n < 200) begin
        @(negedge i_clk);
        n++;
      end
      if (got_evs.size() > ev_rd) begin
        $display("ERROR at %0t ns: control packet reached the AER output", $time);
        err_cnt++;
        ev_rd = got_evs.size();
      end
    end
  endtask

  task automatic run_entry(input int idx, input entry_t e);
    int errs_before;
    errs_before = err_cnt;
    case (e.kind)
      K_AER: begin
        drive_aer_event(e.val[AER_BITS-1:0]);
        expect_pkt(e.has_exp, e.exp);
      end
      K_PKT: begin
        send_pkt(e.val);
        expect_ev(e.has_exp, e.exp);
      end
      default: begin
        // peer stalls past the dump timeout
        @(posedge i_clk);
        #1;
        i_ipkt_rdy = 1'b0;
        drive_aer_event(e.val[AER_BITS-1:0]);
        repeat (DUMP_TIMEOUT + 20) @(posedge i_clk);
        @(negedge i_clk);
        check_value("o_ipkt_vld", '0, PKT_BITS'(o_ipkt_vld));
        @(posedge i_clk);
        #1;
        i_ipkt_rdy = 1'b1;
        // a packet kept past the dump would leave now
        repeat (2) @(negedge i_clk);
        expect_pkt(1'b0, '0);
      end
    endcase
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %0d kind %0d: ok", idx, e.kind);
    end else begin
      fail_cnt++;
      $display("test %0d kind %0d: failed", idx, e.kind);
    end
  endtask

  // --------------------------------------
  // main sequence and watchdog
  // --------------------------------------
  initial begin
    i_arst_n    = 1'b0;
    i_iaer_data = '0;
    i_iaer_req  = 1'b1;
    i_spkt_data = '0;
    i_spkt_vld  = 1'b0;
    i_ipkt_rdy  = 1'b1;
    void'($urandom(32'h80ef_6270));
    build_table();
    n_entries = tests.size();
    repeat (10) @(posedge i_clk);
    #1;
    i_arst_n = 1'b1;
    // idle levels out of reset
    @(negedge i_clk);
    check_value("o_iaer_ack", PKT_BITS'(1), PKT_BITS'(o_iaer_ack));
    check_value("o_oaer_req", PKT_BITS'(1), PKT_BITS'(o_oaer_req));
    check_value("o_ipkt_vld", '0, PKT_BITS'(o_ipkt_vld));
    check_value("o_spkt_rdy", PKT_BITS'(1), PKT_BITS'(o_spkt_rdy));
    $display("reset state: %s", (err_cnt == 0) ? "ok" : "failed");
    for (int i = 0; i < n_entries; i++) begin
      run_entry(i, tests[i]);
    end
    $display("%0d tests passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // 200 cycles per table entry
  initial begin
    wait (n_entries > 0);
    repeat (n_entries * 200 + 20) @(posedge i_clk);
    $display("ERROR: watchdog expired before the table finished");
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
logic/bridge_pkg.sv
logic/aer_in_mapper.sv
logic/pkt_dump.sv
logic/pkt_router.sv
logic/bridge_control.sv
logic/aer_out_mapper.sv
logic/spinn_aer_bridge.sv
tests/bridge_chk.sv
tests/tb_spinn_aer_bridge.sv

/* Makefile */
SOURCES := sim.f $(wildcard logic/*.sv) $(wildcard tests/*.sv)

all: run

obj_dir/Vtb_spinn_aer_bridge: $(SOURCES)
	verilator --binary --timing --assert --top-module tb_spinn_aer_bridge -f sim.f

run: obj_dir/Vtb_spinn_aer_bridge
	./obj_dir/Vtb_spinn_aer_bridge > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Test FAILED" sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
